// File: list.f
+incdir+include
src/event_pkg.sv
src/fsm_pkg.sv
src/channel_ctrl.sv
src/event_router.sv
src/shared_fifo.sv
src/packet_tx.sv
src/digital_core.sv
bench/tb_digital_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the digital core testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
        --top-module tb_digital_core -f list.f -o tb_digital_core --Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_digital_core)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: bench/tb_digital_core.sv
// digital core testbench with adc model, serial decoder, directed tests and watchdog
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_digital_core;

    localparam int N            = `NUM_CHANNELS;
    localparam int CLK_PERIOD   = 4;                               // ns
    localparam int RESET_CYCLES = 4;
    localparam int EVENT_CYCLES = `PACKET_BITS + 2 + 5 + `CSA_RESET_CYCLES + 8; // line, adc, reset
    localparam int ISSUE_LIMIT  = (`FIFO_DEPTH + N + 2) * EVENT_CYCLES; // channel may sit in hold
    localparam int MASK_WINDOW  = 20;
    localparam int BURST_EVENTS = 12;
    localparam int RUN_CYCLES   = RESET_CYCLES + MASK_WINDOW + 8
                                  + (2 + N + BURST_EVENTS) * (ISSUE_LIMIT + EVENT_CYCLES);

    logic                   clk = 1'b0;
    logic                   rst_n_i;
    logic [N-1:0]           hit_i;
    logic [N-1:0]           done_i = '0;                         // driven by adc model
    logic [`ADC_BITS*N-1:0] dout_i = '0;
    logic [N-1:0]           channel_mask_i;
    logic [N-1:0]           sample_o;
    logic [N-1:0]           csa_reset_o;
    logic                   piso_o;

    logic [31:0]            lcg_state = 32'hc0e6_7e37;
    int                     cycle_cnt;                           // cycles since reset release
    bit [N-1:0]             sample_seen;                         // conversion in progress
    int                     adc_wait [N];
    event_pkg::timestamp_t  sample_ts [N];                       // predicted stamp
    event_pkg::packet_t     exp_q [$];                           // sent, not yet received
    bit                     rx_active;
    int                     rx_idx;
    logic [`PACKET_BITS-1:0] rx_bits;
    int                     rx_count, error_count, tests_passed, tests_failed;

    digital_core digital_core_inst (
        .clk (clk), .rst_n_i (rst_n_i), .hit_i (hit_i), .done_i (done_i), .dout_i (dout_i),
        .channel_mask_i (channel_mask_i), .sample_o (sample_o),
        .csa_reset_o (csa_reset_o), .piso_o (piso_o)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        if (!rst_n_i) cycle_cnt <= 0;
        else cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;   // numerical recipes lcg
        return lcg_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and reporting
    task automatic report_failure(input string msg);
        $display("failure at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s expected %b, got %b", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic compare_packet(input string name, input event_pkg::packet_t got,
                                  input event_pkg::packet_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    // oldest pending event of the same channel, so per-channel order is enforced
    task automatic match_packet(input event_pkg::packet_t got);
        int idx;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i].chan_id == got.chan_id) idx = i;
        end
        compare_bit("packet odd parity", ^got, 1'b1);
        if (idx < 0) begin
            report_failure($sformatf("packet from channel %0d with no event pending", got.chan_id));
        end else begin
            compare_packet("received packet", got, exp_q[idx]);
            exp_q.delete(idx);
        end
        rx_count++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // adc model, answers sample_o with done_i after 1 to 5 cycles
    always @(negedge clk) begin : adc_model
        event_pkg::packet_t   exp_pkt;
        event_pkg::adc_word_t adc;
        for (int c = 0; c < N; c++) begin
            done_i[c] = 1'b0;
            if (rst_n_i && sample_o[c] && !sample_seen[c]) begin     // new request
                sample_seen[c] = 1'b1;
                adc_wait[c]    = 1 + int'(next_random() % 32'd5);
                sample_ts[c]   = event_pkg::timestamp_t'(cycle_cnt - 1); // count at rise
            end
            if (sample_seen[c] && adc_wait[c] > 0) begin
                adc_wait[c]--;
                if (adc_wait[c] == 0) begin
                    adc = event_pkg::adc_word_t'(next_random() >> 16);
                    dout_i[c*`ADC_BITS +: `ADC_BITS] = adc;
                    done_i[c]         = 1'b1;
                    exp_pkt.parity    = 1'b0;
                    exp_pkt.chan_id   = event_pkg::chan_id_t'(c);
                    exp_pkt.timestamp = sample_ts[c];
                    exp_pkt.adc       = adc;
                    exp_pkt.parity    = ~(^exp_pkt);                  // make total odd
                    exp_q.push_back(exp_pkt);
                end
            end
            if (!sample_o[c]) sample_seen[c] = 1'b0;
        end
    end

    // serial decoder, start 0, data lsb first, stop 1
    always @(negedge clk) begin : serial_decoder
        if (!rst_n_i) begin
            rx_active = 1'b0;
        end else if (!rx_active) begin
            rx_active = (piso_o == 1'b0);
            rx_idx    = 0;
        end else if (rx_idx < `PACKET_BITS) begin
            rx_bits[rx_idx] = piso_o;
            rx_idx++;
        end else begin
            compare_bit("piso_o stop bit", piso_o, 1'b1);
            match_packet(event_pkg::packet_t'(rx_bits));
            rx_active = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    function automatic bit line_quiet();
        return exp_q.size() == 0 && sample_o == '0 && csa_reset_o == '0 && !rx_active
               && piso_o === 1'b1;
    endfunction

    // raise hit until the channel answers with sample_o
    task automatic issue_hit(input int c);
        int cycles;
        cycles = 0;
        while (sample_o[c] && cycles < ISSUE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        hit_i[c] = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!sample_o[c] && cycles < ISSUE_LIMIT);
        hit_i[c] = 1'b0;
        if (!sample_o[c]) report_failure($sformatf("channel %0d never raised sample_o", c));
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        bit quiet;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            quiet = line_quiet();
        end while (!quiet && cycles < limit);
        @(negedge clk);
        if (!quiet) report_failure($sformatf("events still pending after %0d cycles", limit));
    endtask

    task automatic check_packet_count(input int rx_before, input int expected);
        if (rx_count - rx_before != expected)
            report_failure($sformatf("expected %0d packets, received %0d", expected,
                                     rx_count - rx_before));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    task automatic check_reset_state();
        int errs;
        errs = error_count;
        compare_bit("piso_o", piso_o, 1'b1);
        for (int c = 0; c < N; c++) begin
            compare_bit($sformatf("sample_o[%0d]", c), sample_o[c], 1'b0);
            compare_bit($sformatf("csa_reset_o[%0d]", c), csa_reset_o[c], 1'b0);
        end
        finish_test("reset_state", errs);
    endtask

    task automatic single_hit(input int c);
        int errs, rx_before;
        errs      = error_count;
        rx_before = rx_count;
        issue_hit(c);                       // id, stamp and adc checked on arrival
        wait_drain(EVENT_CYCLES);
        check_packet_count(rx_before, 1);
        finish_test("single_hit", errs);
    endtask

    task automatic amp_reset_length(input int c);
        int errs, cycles;
        errs   = error_count;
        cycles = 0;
        issue_hit(c);
        do begin
            @(posedge clk);                 // capture edge
            cycles++;
        end while (!done_i[c] && cycles < EVENT_CYCLES);
        if (!done_i[c]) report_failure("adc model never answered");
        for (int k = 0; k < `CSA_RESET_CYCLES; k++) begin
            @(negedge clk);
            compare_bit($sformatf("csa_reset_o[%0d]", c), csa_reset_o[c], 1'b1);
        end
        @(negedge clk);
        compare_bit($sformatf("csa_reset_o[%0d]", c), csa_reset_o[c], 1'b0);
        wait_drain(EVENT_CYCLES);
        finish_test("amp_reset_length", errs);
    endtask

    task automatic masked_channel(input int c);
        int errs, rx_before;
        errs              = error_count;
        rx_before         = rx_count;
        channel_mask_i[c] = 1'b1;
        hit_i[c]          = 1'b1;
        repeat (MASK_WINDOW) begin
            @(negedge clk);
            compare_bit($sformatf("sample_o[%0d]", c), sample_o[c], 1'b0);
        end
        hit_i[c] = 1'b0;
        wait_drain(EVENT_CYCLES);
        channel_mask_i[c] = 1'b0;
        check_packet_count(rx_before, 0);
        finish_test("masked_channel", errs);
    endtask

    task automatic simultaneous_hits();
        int errs, rx_before;
        errs      = error_count;
        rx_before = rx_count;
        hit_i     = '1;
        @(negedge clk);
        hit_i = '0;
        for (int c = 0; c < N; c++) compare_bit($sformatf("sample_o[%0d]", c), sample_o[c], 1'b1);
        wait_drain(N * EVENT_CYCLES);
        check_packet_count(rx_before, N);
        finish_test("simultaneous_hits", errs);
    endtask

    // hits come faster than the line drains, fifo fills and channels wait in hold
    task automatic backpressure_burst();
        int errs, rx_before;
        errs      = error_count;
        rx_before = rx_count;
        for (int ev = 0; ev < BURST_EVENTS; ev++) issue_hit(ev % N);
        wait_drain(BURST_EVENTS * EVENT_CYCLES);
        check_packet_count(rx_before, BURST_EVENTS);
        finish_test("backpressure_burst", errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin : main
        rst_n_i        = 1'b0;
        hit_i          = '0;
        channel_mask_i = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        check_reset_state();
        single_hit(1);
        amp_reset_length(3);
        masked_channel(2);
        simultaneous_hits();
        backpressure_burst();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", RUN_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// File: src/digital_core.sv
// digital core top with timestamp counter, channel controllers, router, fifo and serializer
`timescale 1ns/1ps
`include "core_settings.svh"

module digital_core (
    input  logic                              clk,            // core clock
    input  logic                              rst_n_i,        // sync reset, active low
    input  logic [`NUM_CHANNELS-1:0]          hit_i,          // discriminator hits
    input  logic [`NUM_CHANNELS-1:0]          done_i,         // adc conversions done
    input  logic [`ADC_BITS*`NUM_CHANNELS-1:0] dout_i,        // all adc words
    input  logic [`NUM_CHANNELS-1:0]          channel_mask_i, // high disables channel
    output logic [`NUM_CHANNELS-1:0]          sample_o,       // adc sample request
    output logic [`NUM_CHANNELS-1:0]          csa_reset_o,    // charge amp resets
    output logic                              piso_o          // serial packet line
);

    event_pkg::timestamp_t      timestamp_q;                  // free-running time
    event_pkg::adc_word_t       adc_word [`NUM_CHANNELS];     // per-channel adc
    event_pkg::packet_t         events [`NUM_CHANNELS];       // held packets
    logic [`NUM_CHANNELS-1:0]   event_ready;                  // channels in hold
    logic [`NUM_CHANNELS-1:0]   read_chan;                    // router releases
    event_pkg::packet_t         router_packet;                // packet with parity
    logic                       fifo_write;
    logic                       fifo_read;
    logic                       fifo_full;
    logic                       fifo_empty;
    event_pkg::packet_t         fifo_head;                    // show-ahead head

    ////////////////////////////////////////////////////////////////////////
    // timestamp, zero in the first cycle after reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) timestamp_q <= '0;
        else timestamp_q <= timestamp_q + 1'b1;   // wraps at full width
    end

    ////////////////////////////////////////////////////////////////////////
    // channels
    for (genvar g = 0; g < `NUM_CHANNELS; g++) begin : g_chan
        assign adc_word[g] = dout_i[g*`ADC_BITS +: `ADC_BITS];   // split adc bus

        channel_ctrl channel_ctrl_inst (
            .clk           (clk),
            .rst_n_i       (rst_n_i),
            .chan_id_i     (event_pkg::chan_id_t'(g)),
            .hit_i         (hit_i[g]),
            .masked_i      (channel_mask_i[g]),
            .done_i        (done_i[g]),
            .dout_i        (adc_word[g]),
            .timestamp_i   (timestamp_q),
            .read_i        (read_chan[g]),
            .sample_o      (sample_o[g]),
            .csa_reset_o   (csa_reset_o[g]),
            .event_ready_o (event_ready[g]),
            .event_o       (events[g])
        );
    end

    event_router event_router_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .event_ready_i (event_ready),
        .events_i      (events),
        .fifo_full_i   (fifo_full),
        .read_o        (read_chan),
        .write_o       (fifo_write),
        .packet_o      (router_packet)
    );

    shared_fifo #(.DEPTH(`FIFO_DEPTH)) shared_fifo_inst (
        .clk (clk), .rst_n_i (rst_n_i),
        .write_i (fifo_write), .data_i (router_packet),
        .read_i (fifo_read), .data_o (fifo_head),
        .empty_o (fifo_empty), .full_o (fifo_full)
    );

    packet_tx packet_tx_inst (
        .clk (clk), .rst_n_i (rst_n_i),
        .fifo_empty_i (fifo_empty), .fifo_data_i (fifo_head),
        .fifo_read_o (fifo_read), .piso_o (piso_o)
    );

endmodule

// File: src/packet_tx.sv
// serializer framing each fifo packet as start bit, 32 data bits lsb first and stop bit
`timescale 1ns/1ps
`include "core_settings.svh"

module packet_tx (
    input  logic               clk,             // core clock
    input  logic               rst_n_i,         // sync reset, active low
    input  logic               fifo_empty_i,    // nothing to send
    input  event_pkg::packet_t fifo_data_i,     // fifo head
    output logic               fifo_read_o,     // pop head
    output logic               piso_o           // serial line, idles high
);

    localparam int BIT_CNT_BITS = $clog2(`PACKET_BITS);

    fsm_pkg::tx_state_e      state_q;     // framing state
    logic [`PACKET_BITS-1:0] shift_q;     // data bits, lsb goes out first
    logic [BIT_CNT_BITS-1:0] bit_cnt_q;   // data bits sent so far
    logic                    load;

    ////////////////////////////////////////////////////////////////////////
    // pop when idle or right after a stop bit
    assign load = ((state_q == fsm_pkg::TX_IDLE) || (state_q == fsm_pkg::TX_STOP))
                  && !fifo_empty_i;
    assign fifo_read_o = load;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= fsm_pkg::TX_IDLE;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                fsm_pkg::TX_IDLE: begin
                    if (load) state_q <= fsm_pkg::TX_START;
                end
                fsm_pkg::TX_START: begin
                    state_q   <= fsm_pkg::TX_DATA;
                    bit_cnt_q <= '0;
                end
                fsm_pkg::TX_DATA: begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == BIT_CNT_BITS'(`PACKET_BITS - 1)) begin
                        state_q <= fsm_pkg::TX_STOP;    // last data bit out
                    end
                end
                default: begin                          // TX_STOP
                    state_q <= load ? fsm_pkg::TX_START : fsm_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // shift register holds payload only
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= fifo_data_i;                     // latch popped packet
        end else if (state_q == fsm_pkg::TX_DATA) begin
            shift_q <= {1'b0, shift_q[`PACKET_BITS-1:1]};
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // line level per state
    always_comb begin
        case (state_q)
            fsm_pkg::TX_START: piso_o = 1'b0;           // start bit
            fsm_pkg::TX_DATA:  piso_o = shift_q[0];     // current data bit
            default:           piso_o = 1'b1;           // idle and stop
        endcase
    end

endmodule

// File: src/shared_fifo.sv
// show-ahead packet fifo between event router and serializer
`timescale 1ns/1ps
`include "core_settings.svh"

module shared_fifo #(
    parameter int DEPTH = `FIFO_DEPTH           // packet locations
) (
    input  logic               clk,             // core clock
    input  logic               rst_n_i,         // sync reset, active low
    input  logic               write_i,         // push strobe
    input  event_pkg::packet_t data_i,          // packet to push
    input  logic               read_i,          // pop strobe
    output event_pkg::packet_t data_o,          // current head
    output logic               empty_o,         // nothing stored
    output logic               full_o           // no room left
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    event_pkg::packet_t  mem [DEPTH];     // storage
    logic [PTR_BITS-1:0] wr_ptr_q;        // next free slot
    logic [PTR_BITS-1:0] rd_ptr_q;        // head slot
    logic [CNT_BITS-1:0] count_q;         // occupancy
    logic                do_write;
    logic                do_read;

    assign do_write = write_i && !full_o;
    assign do_read  = read_i && !empty_o;

    ////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr_q] <= data_i;
    end

    ////////////////////////////////////////////////////////////////////////
    // show-ahead outputs
    assign data_o  = mem[rd_ptr_q];               // valid while not empty
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_BITS'(DEPTH));

    // router and serializer must respect the flags
    no_write_full_a: assert property (
        @(posedge clk) disable iff (!rst_n_i) write_i |-> !full_o
    );
    no_read_empty_a: assert property (
        @(posedge clk) disable iff (!rst_n_i) read_i |-> !empty_o
    );

endmodule

// File: src/event_router.sv
// round-robin collection of held channel packets into the shared fifo with odd parity
`timescale 1ns/1ps
`include "core_settings.svh"

module event_router (
    input  logic                    clk,                        // core clock
    input  logic                    rst_n_i,                    // sync reset, active low
    input  logic [`NUM_CHANNELS-1:0] event_ready_i,             // channel in hold
    input  event_pkg::packet_t      events_i [`NUM_CHANNELS],   // held packets
    input  logic                    fifo_full_i,                // back-pressure
    output logic [`NUM_CHANNELS-1:0] read_o,                    // release channel
    output logic                    write_o,                    // push to fifo
    output event_pkg::packet_t      packet_o                    // packet with parity
);

    localparam int N        = `NUM_CHANNELS;
    localparam int PTR_BITS = (N > 1) ? $clog2(N) : 1;

    logic [PTR_BITS-1:0] ptr_q;     // first channel to look at
    logic [PTR_BITS-1:0] sel;       // chosen channel
    logic                found;     // some channel ready
    event_pkg::packet_t  pkt;

    ////////////////////////////////////////////////////////////////////////
    // pick first ready channel at or after pointer
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr_q) + i) % N;            // wrap in index order
            if (!found && event_ready_i[idx]) begin
                found = 1'b1;
                sel   = PTR_BITS'(idx);
            end
        end
    end

    assign write_o = found && !fifo_full_i;         // hold everything while full
    assign read_o  = write_o ? (N'(1) << sel) : '0; // paired with the write

    always_comb begin
        pkt        = events_i[sel];
        pkt.parity = ~(^{pkt.chan_id, pkt.timestamp, pkt.adc});   // odd overall
    end
    assign packet_o = pkt;

    // pointer moves past the channel just served
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (write_o) begin
            ptr_q <= (int'(sel) == N - 1) ? '0 : sel + 1'b1;
        end
    end

    // at most one channel released per cycle
    read_one_hot_a: assert property (
        @(posedge clk) disable iff (!rst_n_i) $onehot0(read_o)
    );

endmodule

// File: src/channel_ctrl.sv
// per-channel controller for hit, sample, adc capture, csa reset and packet hold
`timescale 1ns/1ps
`include "core_settings.svh"

module channel_ctrl (
    input  logic                  clk,            // core clock
    input  logic                  rst_n_i,        // sync reset, active low
    input  event_pkg::chan_id_t   chan_id_i,      // this channel's number
    input  logic                  hit_i,          // discriminator fired
    input  logic                  masked_i,       // high disables channel
    input  logic                  done_i,         // adc conversion finished
    input  event_pkg::adc_word_t  dout_i,         // adc result
    input  event_pkg::timestamp_t timestamp_i,    // free-running time
    input  logic                  read_i,         // router took the packet
    output logic                  sample_o,       // hold csa output for adc
    output logic                  csa_reset_o,    // charge amp reset
    output logic                  event_ready_o,  // packet waiting in hold
    output event_pkg::packet_t    event_o         // held packet, parity zero
);

    localparam int RST_CNT_BITS = $clog2(`CSA_RESET_CYCLES + 1);

    fsm_pkg::chan_state_e   state_q;     // sequence state
    logic [RST_CNT_BITS-1:0] rst_cnt_q;  // csa reset cycles left
    event_pkg::timestamp_t  ts_q;        // time of sample start
    event_pkg::adc_word_t   adc_q;       // captured conversion
    logic                   start_sample;
    logic                   capture;

    ////////////////////////////////////////////////////////////////////////
    // sequencing
    assign start_sample = (state_q == fsm_pkg::CH_IDLE) && hit_i && !masked_i;
    assign capture      = (state_q == fsm_pkg::CH_SAMPLE) && done_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= fsm_pkg::CH_IDLE;
            rst_cnt_q <= '0;
        end else begin
            case (state_q)
                fsm_pkg::CH_IDLE: begin
                    if (start_sample) state_q <= fsm_pkg::CH_SAMPLE;
                end
                fsm_pkg::CH_SAMPLE: begin
                    if (capture) begin
                        state_q   <= fsm_pkg::CH_RESET;
                        rst_cnt_q <= RST_CNT_BITS'(`CSA_RESET_CYCLES - 1); // first cycle counts
                    end
                end
                fsm_pkg::CH_RESET: begin
                    if (rst_cnt_q == '0) state_q <= fsm_pkg::CH_HOLD;
                    else rst_cnt_q <= rst_cnt_q - 1'b1;
                end
                default: begin                                  // CH_HOLD
                    if (read_i) state_q <= fsm_pkg::CH_IDLE;
                end
            endcase
        end
    end

    // payload, latched on the same edges as the state changes
    always_ff @(posedge clk) begin
        if (start_sample) ts_q <= timestamp_i;   // stamp at sample rise
        if (capture) adc_q <= dout_i;            // word valid with done
    end

    ////////////////////////////////////////////////////////////////////////
    // outputs decoded from state
    assign sample_o      = (state_q == fsm_pkg::CH_SAMPLE);
    assign csa_reset_o   = (state_q == fsm_pkg::CH_RESET);
    assign event_ready_o = (state_q == fsm_pkg::CH_HOLD);

    always_comb begin
        event_o.parity    = 1'b0;       // router fills this in
        event_o.chan_id   = chan_id_i;
        event_o.timestamp = ts_q;
        event_o.adc       = adc_q;
    end

    // adc must never sample a csa that is being reset
    sample_vs_reset_a: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(sample_o && csa_reset_o)
    );

endmodule

// File: src/fsm_pkg.sv
// state encodings of the channel controller and the packet serializer
`include "core_settings.svh"

package fsm_pkg;

    // channel controller sequence
    typedef enum logic [1:0] {
        CH_IDLE   = 2'd0,   // waiting for a hit
        CH_SAMPLE = 2'd1,   // adc converting
        CH_RESET  = 2'd2,   // csa being reset
        CH_HOLD   = 2'd3    // packet held for router
    } chan_state_e;

    // serializer framing
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,    // line high
        TX_START = 2'd1,    // start bit 0
        TX_DATA  = 2'd2,    // 32 data bits lsb first
        TX_STOP  = 2'd3     // stop bit 1
    } tx_state_e;

endpackage

// File: src/event_pkg.sv
// event packet struct and the channel id, adc word and timestamp types
`include "core_settings.svh"

package event_pkg;

    ////////////////////////////////////////////////////////////////////////
    // field types
    typedef logic [`CHAN_ID_BITS-1:0]   chan_id_t;     // channel number
    typedef logic [`ADC_BITS-1:0]       adc_word_t;    // one adc result
    typedef logic [`TIMESTAMP_BITS-1:0] timestamp_t;   // event time

    ////////////////////////////////////////////////////////////////////////
    // 32-bit event packet with msb field first
    // bit 31 parity, 30..27 id, 26..10 timestamp, 9..0 adc
    typedef struct packed {
        logic       parity;     // odd parity over whole packet
        chan_id_t   chan_id;    // source channel
        timestamp_t timestamp;  // time of sample rising edge
        adc_word_t  adc;        // captured conversion
    } packet_t;

endpackage

// File: include/core_settings.svh
// channel count, field widths, FIFO depth and amplifier reset length
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////
// channel array
`define NUM_CHANNELS 4          // analog channels on the core
`define CHAN_ID_BITS 4          // channel number field

////////////////////////////////////////////////////////////////////////
// event packet fields
`define ADC_BITS 10             // one conversion
`define TIMESTAMP_BITS 17       // free-running counter, wraps
`define PACKET_BITS 32          // parity + id + timestamp + adc

////////////////////////////////////////////////////////////////////////
// buffering and analog timing
`define FIFO_DEPTH 4            // shared fifo locations
`define CSA_RESET_CYCLES 3      // length of charge amp reset

`endif
